//--- source/wb_mem_pkg.sv
// Region map, sizes, enums and bus structs of the Wishbone memory system; import with wb_mem_pkg::*
`default_nettype none

package wb_mem_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int XLEN  = 32;
  localparam int PLEN  = 32;
  localparam int SEL_W = XLEN / 8;

  ////////////////////
  // Memory map
  ////////////////////
  localparam logic [PLEN-1:0] RAM_BASE    = 32'h8000_0000;
  localparam int              RAM_WORDS   = 1024;
  localparam int              RAM_AW      = $clog2(RAM_WORDS);
  localparam logic [PLEN-1:0] TOHOST_ADR  = 32'h8000_1000;
  localparam logic [PLEN-1:0] UART_TX_ADR = 32'h8000_1080;

  // Decoded target of an access
  typedef enum logic [1:0] {
    REGION_NONE   = 2'd0,
    REGION_RAM    = 2'd1,
    REGION_TOHOST = 2'd2,
    REGION_UART   = 2'd3
  } mem_region_e;

  // Read, write, execute
  typedef struct packed {
    logic r;
    logic w;
    logic x;
  } pma_rights_t;

  // Fixed rights per region
  localparam pma_rights_t RAM_RIGHTS    = '{r: 1'b1, w: 1'b1, x: 1'b1};
  localparam pma_rights_t TOHOST_RIGHTS = '{r: 1'b1, w: 1'b1, x: 1'b0};
  localparam pma_rights_t UART_RIGHTS   = '{r: 1'b0, w: 1'b1, x: 1'b0};
  localparam pma_rights_t NO_RIGHTS     = '{r: 1'b0, w: 1'b0, x: 1'b0};

  ////////////////////
  // Bus records
  ////////////////////
  // Classic Wishbone request, master to slave
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [PLEN-1:0]  adr;
    logic [XLEN-1:0]  dat;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    logic            ack;
    logic            err;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

  // Port controller to one RAM port
  typedef struct packed {
    logic              en;
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [RAM_AW-1:0] idx;
    logic [XLEN-1:0]   wdat;
  } ram_req_t;

  // Data port controller to host MMIO
  typedef struct packed {
    logic             en;
    logic             we;
    logic [SEL_W-1:0] sel;
    mem_region_e      target;
    logic [XLEN-1:0]  wdat;
  } mmio_req_t;

endpackage

`default_nettype wire

//--- source/pma_check.sv
// Combinational PMA lookup; maps a bus address to its region and access rights
`default_nettype none

module pma_check
  import wb_mem_pkg::*;
(
  input  wire logic [PLEN-1:0] adr_i,
  output mem_region_e          region_o,
  output pma_rights_t          rights_o
);

  // RAM is aligned on its own size, so a tag compare is enough
  localparam int RAM_LSB = RAM_AW + 2;

  logic hit_ram;
  logic hit_tohost;
  logic hit_uart;

  ////////////////////
  // Address match
  ////////////////////
  assign hit_ram    = (adr_i[PLEN-1:RAM_LSB] == RAM_BASE[PLEN-1:RAM_LSB]);
  // MMIO words match on the full address
  assign hit_tohost = (adr_i == TOHOST_ADR);
  assign hit_uart   = (adr_i == UART_TX_ADR);

  ////////////////////
  // Region and rights
  ////////////////////
  always_comb begin
    // Unmapped by default
    region_o = REGION_NONE;
    rights_o = NO_RIGHTS;
    if (hit_ram) begin
      region_o = REGION_RAM;
      rights_o = RAM_RIGHTS;
    end else if (hit_tohost) begin
      region_o = REGION_TOHOST;
      rights_o = TOHOST_RIGHTS;
    end else if (hit_uart) begin
      // Transmit only, no readback
      region_o = REGION_UART;
      rights_o = UART_RIGHTS;
    end
  end

endmodule

`default_nettype wire

//--- source/wb_port_ctrl.sv
// Wishbone slave controller for one bus port; checks PMA, routes to RAM or MMIO, returns ack/err
`default_nettype none

module wb_port_ctrl
  import wb_mem_pkg::*;
#(
  parameter bit FETCH_PORT = 1'b0
) (
  input  wire logic            HCLK,
  input  wire logic            rst_n_i,
  input  wire wb_req_t         req_i,
  output wb_rsp_t              rsp_o,
  output ram_req_t             ram_o,
  input  wire logic [XLEN-1:0] ram_rdat_i,
  output mmio_req_t            mmio_o,
  input  wire logic [XLEN-1:0] mmio_rdat_i
);

  mem_region_e region;
  pma_rights_t rights;
  logic        accept;
  logic        allow;
  logic        is_ram;
  logic        ack_q;
  logic        err_q;
  mem_region_e tgt_q;

  pma_check pma (
    .adr_i   (req_i.adr),
    .region_o(region),
    .rights_o(rights)
  );

  ////////////////////
  // Request decode
  ////////////////////
  // New cycle only once the previous response is gone
  assign accept = req_i.cyc && req_i.stb && !(ack_q || err_q);
  assign is_ram = (region == REGION_RAM);

  always_comb begin
    if (FETCH_PORT) begin
      // Fetch needs x, never writes, RAM only
      allow = rights.x && !req_i.we && is_ram;
    end else if (req_i.we) begin
      allow = rights.w;
    end else begin
      allow = rights.r;
    end
  end

  // RAM side
  always_comb begin
    ram_o.en   = accept && allow && is_ram;
    ram_o.we   = req_i.we;
    ram_o.sel  = req_i.sel;
    ram_o.idx  = req_i.adr[RAM_AW+1:2];
    ram_o.wdat = req_i.dat;
  end

  // MMIO side, idle on the fetch port
  always_comb begin
    mmio_o = '0;
    if (!FETCH_PORT) begin
      mmio_o.en     = accept && allow && !is_ram;
      mmio_o.we     = req_i.we;
      mmio_o.sel    = req_i.sel;
      mmio_o.target = region;
      mmio_o.wdat   = req_i.dat;
    end
  end

  ////////////////////
  // Response
  ////////////////////
  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      tgt_q <= REGION_NONE;
    end else begin
      ack_q <= accept && allow;
      err_q <= accept && !allow;
      // Target of the access now in flight
      if (accept) begin
        tgt_q <= allow ? region : REGION_NONE;
      end
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = err_q;
    case (tgt_q)
      REGION_RAM:                 rsp_o.dat = ram_rdat_i;
      REGION_TOHOST, REGION_UART: rsp_o.dat = FETCH_PORT ? '0 : mmio_rdat_i;
      default:                    rsp_o.dat = '0;
    endcase
  end

  // Ack and err are exclusive
  a_ack_err_excl: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(rsp_o.ack && rsp_o.err));

  // Every response answers a strobe from the cycle before
  // An ack also needs an access that reached the RAM or MMIO
  a_rsp_after_req: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (rsp_o.ack || rsp_o.err) |->
      $past(req_i.cyc && req_i.stb) &&
      (rsp_o.err || $past(ram_o.en || mmio_o.en)));

endmodule

`default_nettype wire

//--- source/wb_dual_ram.sv
// Two-port word RAM; read-only fetch port plus byte-enabled data port, both with registered reads
`default_nettype none

module wb_dual_ram
  import wb_mem_pkg::*;
(
  input  wire logic     HCLK,
  input  wire ram_req_t fetch_i,
  output logic [XLEN-1:0] fetch_rdat_o,
  input  wire ram_req_t data_i,
  output logic [XLEN-1:0] data_rdat_o
);

  // Storage array
  logic [XLEN-1:0] mem [RAM_WORDS];

  ////////////////////
  // Fetch port
  ////////////////////
  // Sees the old word if the data port writes it in the same cycle
  always_ff @(posedge HCLK) begin
    if (fetch_i.en) begin
      fetch_rdat_o <= mem[fetch_i.idx];
    end
  end

  ////////////////////
  // Data port
  ////////////////////
  always_ff @(posedge HCLK) begin
    if (data_i.en) begin
      if (data_i.we) begin
        // Byte lanes by sel
        for (int b = 0; b < SEL_W; b++) begin
          if (data_i.sel[b]) begin
            mem[data_i.idx][8*b +: 8] <= data_i.wdat[8*b +: 8];
          end
        end
      end
      // Read before write
      data_rdat_o <= mem[data_i.idx];
    end
  end

  // Fetch controller filters writes before they reach the array
  a_fetch_no_we: assert property (@(posedge HCLK)
    fetch_i.en |-> !fetch_i.we);

  // Data port write with nothing selected would be a wasted cycle upstream
  a_data_sel: assert property (@(posedge HCLK)
    (data_i.en && data_i.we) |-> (data_i.sel != '0));

endmodule

`default_nettype wire

//--- source/mmio_host_if.sv
// Host MMIO block; holds the tohost word for test-done detection and strobes UART transmit bytes
`default_nettype none

module mmio_host_if
  import wb_mem_pkg::*;
(
  input  wire logic       HCLK,
  input  wire logic       rst_n_i,
  input  wire mmio_req_t  req_i,
  output logic [XLEN-1:0] rdat_o,
  output logic            test_done_o,
  output logic [XLEN-2:0] test_code_o,
  output logic            uart_valid_o,
  output logic [7:0]      uart_data_o
);

  logic [XLEN-1:0] tohost_q;
  logic            wr_tohost;
  logic            wr_uart;

  assign wr_tohost = req_i.en && req_i.we && (req_i.target == REGION_TOHOST);
  assign wr_uart   = req_i.en && req_i.we && (req_i.target == REGION_UART);

  ////////////////////
  // tohost
  ////////////////////
  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tohost_q <= '0;
    end else if (wr_tohost) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (req_i.sel[b]) begin
          tohost_q[8*b +: 8] <= req_i.wdat[8*b +: 8];
        end
      end
    end
  end

  // Bit 0 flags the end of test, rest is the code
  assign test_done_o = tohost_q[0];
  assign test_code_o = tohost_q[XLEN-1:1];

  // Readback one clock after the request
  always_ff @(posedge HCLK) begin
    if (req_i.en && !req_i.we) begin
      rdat_o <= (req_i.target == REGION_TOHOST) ? tohost_q : '0;
    end
  end

  ////////////////////
  // UART transmit
  ////////////////////
  // Pulse lines up with the ack of the write
  always_ff @(posedge HCLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      uart_valid_o <= 1'b0;
    end else begin
      uart_valid_o <= wr_uart;
    end
  end

  // Low byte only
  always_ff @(posedge HCLK) begin
    if (wr_uart) begin
      uart_data_o <= req_i.wdat[7:0];
    end
  end

  // RAM and unmapped accesses never get routed here
  a_target_mmio: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    req_i.en |-> (req_i.target inside {REGION_TOHOST, REGION_UART}));

endmodule

`default_nettype wire

//--- source/wb_mem_sys.sv
// Top level of the memory side; instruction and data Wishbone slaves over shared RAM and host MMIO
`default_nettype none

module wb_mem_sys
  import wb_mem_pkg::*;
(
  input  wire logic       HCLK,
  input  wire logic       rst_n_i,
  input  wire wb_req_t    ins_req_i,
  input  wire wb_req_t    dat_req_i,
  output wb_rsp_t         ins_rsp_o,
  output wb_rsp_t         dat_rsp_o,
  output logic            test_done_o,
  output logic [XLEN-2:0] test_code_o,
  output logic            uart_valid_o,
  output logic [7:0]      uart_data_o
);

  ram_req_t        ins_ram;
  ram_req_t        dat_ram;
  logic [XLEN-1:0] ins_ram_rdat;
  logic [XLEN-1:0] dat_ram_rdat;
  mmio_req_t       dat_mmio;
  logic [XLEN-1:0] mmio_rdat;

  ////////////////////
  // Bus ports
  ////////////////////
  // Instruction fetch, RAM only
  wb_port_ctrl #(.FETCH_PORT(1'b1)) ins_port (
    .HCLK       (HCLK),
    .rst_n_i    (rst_n_i),
    .req_i      (ins_req_i),
    .rsp_o      (ins_rsp_o),
    .ram_o      (ins_ram),
    .ram_rdat_i (ins_ram_rdat),
    .mmio_o     (),
    .mmio_rdat_i()
  );

  // Data, RAM plus MMIO
  wb_port_ctrl #(.FETCH_PORT(1'b0)) dat_port (
    .HCLK       (HCLK),
    .rst_n_i    (rst_n_i),
    .req_i      (dat_req_i),
    .rsp_o      (dat_rsp_o),
    .ram_o      (dat_ram),
    .ram_rdat_i (dat_ram_rdat),
    .mmio_o     (dat_mmio),
    .mmio_rdat_i(mmio_rdat)
  );

  ////////////////////
  // Targets
  ////////////////////
  wb_dual_ram ram (
    .HCLK        (HCLK),
    .fetch_i     (ins_ram),
    .fetch_rdat_o(ins_ram_rdat),
    .data_i      (dat_ram),
    .data_rdat_o (dat_ram_rdat)
  );

  mmio_host_if mmio (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .req_i       (dat_mmio),
    .rdat_o      (mmio_rdat),
    .test_done_o (test_done_o),
    .test_code_o (test_code_o),
    .uart_valid_o(uart_valid_o),
    .uart_data_o (uart_data_o)
  );

endmodule

`default_nettype wire

//--- tb/wb_mem_sys_tb.sv
// Self-checking testbench for wb_mem_sys; drives both Wishbone masters, built and run by the Makefile
`default_nettype none

module wb_mem_sys_tb
  import wb_mem_pkg::*;
();

  ////////////////////
  // Run length
  ////////////////////
  localparam int N_RAND    = 200;
  localparam int N_FETCH   = 64;
  localparam int N_PAIR    = 64;
  localparam int N_ERR     = 8;
  localparam int N_UART    = 16;
  localparam int N_HOST    = 4;
  localparam int N_TXN     = RAM_WORDS + N_RAND + N_FETCH + N_PAIR + N_ERR + N_UART + N_HOST;
  localparam int WD_TIME   = N_TXN * 4 * 20 + 2000;
  localparam int RSP_LIMIT = 8;

  // Expected response plus the cycle it falls due in
  typedef struct packed {
    wb_rsp_t     rsp;
    logic        chk_dat;
    logic [31:0] at;
  } exp_t;

  logic            HCLK;
  logic            rst_n;
  wb_req_t         ins_req;
  wb_req_t         dat_req;
  wb_rsp_t         ins_rsp;
  wb_rsp_t         dat_rsp;
  logic            test_done;
  logic [XLEN-2:0] test_code;
  logic            uart_valid;
  logic [7:0]      uart_data;

  // Reference state
  logic [XLEN-1:0] model_ram [RAM_WORDS];
  logic [XLEN-1:0] tohost_model = '0;
  exp_t            ins_q[$];
  exp_t            dat_q[$];
  exp_t            uart_q[$];
  logic [31:0]     cyc_cnt = '0;
  logic [15:0]     lfsr = 16'd85;
  int              errors = 0;
  int              checks = 0;
  int              tests = 0;
  int              failed_tests = 0;
  int              err_mark = 0;

  wb_mem_sys dut0 (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n),
    .ins_req_i   (ins_req),
    .dat_req_i   (dat_req),
    .ins_rsp_o   (ins_rsp),
    .dat_rsp_o   (dat_rsp),
    .test_done_o (test_done),
    .test_code_o (test_code),
    .uart_valid_o(uart_valid),
    .uart_data_o (uart_data)
  );

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Cycle count, used to time each response
  always @(posedge HCLK) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  ////////////////////
  // Helpers
  ////////////////////
  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic wb_req_t mk_req(input logic we, input logic [SEL_W-1:0] sel,
                                     input logic [PLEN-1:0] adr, input logic [XLEN-1:0] dat);
    wb_req_t r;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.sel = sel;
    r.adr = adr;
    r.dat = dat;
    return r;
  endfunction

  function automatic logic [PLEN-1:0] ram_adr(input logic [RAM_AW-1:0] idx);
    return RAM_BASE | PLEN'({idx, 2'b00});
  endfunction

  // Every address bit reaches the word
  function automatic logic [XLEN-1:0] fill_word(input logic [PLEN-1:0] adr);
    return {adr[23:0], adr[31:24]} ^ 32'h3C5A_A5C3;
  endfunction

  function automatic logic [XLEN-1:0] byte_merge(input logic [XLEN-1:0] old,
                                                 input logic [XLEN-1:0] wdat,
                                                 input logic [SEL_W-1:0] sel);
    logic [XLEN-1:0] v;
    v = old;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) v[8*b +: 8] = wdat[8*b +: 8];
    end
    return v;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  // Region map as a plain range table
  function automatic mem_region_e region_of(input logic [PLEN-1:0] adr);
    if (adr >= RAM_BASE && adr < RAM_BASE + PLEN'(4 * RAM_WORDS)) return REGION_RAM;
    if (adr == TOHOST_ADR) return REGION_TOHOST;
    if (adr == UART_TX_ADR) return REGION_UART;
    return REGION_NONE;
  endfunction

  // Fetch needs x, data read needs r, data write needs w
  function automatic logic access_ok(input logic fetch, input logic we, input mem_region_e rgn);
    if (fetch) return !we && rgn == REGION_RAM;
    if (we) return rgn != REGION_NONE;
    return rgn == REGION_RAM || rgn == REGION_TOHOST;
  endfunction

  function automatic exp_t ref_rsp(input logic fetch, input wb_req_t r, input logic [31:0] at);
    exp_t        e;
    mem_region_e rgn;
    logic        ok;
    rgn = region_of(r.adr);
    ok  = access_ok(fetch, r.we, rgn);
    e   = '0;
    e.at      = at;
    e.rsp.ack = ok;
    e.rsp.err = !ok;
    e.chk_dat = ok && !r.we;
    if (e.chk_dat && rgn == REGION_RAM) e.rsp.dat = model_ram[r.adr[RAM_AW+1:2]];
    if (e.chk_dat && rgn == REGION_TOHOST) e.rsp.dat = tohost_model;
    return e;
  endfunction

  // Side effects of an allowed data write
  function automatic void update_model(input wb_req_t r, input logic [31:0] at);
    mem_region_e rgn;
    exp_t        e;
    rgn = region_of(r.adr);
    if (r.we && access_ok(1'b0, 1'b1, rgn)) begin
      case (rgn)
        REGION_RAM: begin
          model_ram[r.adr[RAM_AW+1:2]] = byte_merge(model_ram[r.adr[RAM_AW+1:2]], r.dat, r.sel);
        end
        REGION_TOHOST: tohost_model = byte_merge(tohost_model, r.dat, r.sel);
        default: begin
          // UART pulse, due with the ack
          e = '0;
          e.rsp.ack = 1'b1;
          e.rsp.dat = {24'h0, r.dat[7:0]};
          e.at      = at;
          uart_q.push_back(e);
        end
      endcase
    end
  endfunction

  ////////////////////
  // Checks
  ////////////////////
  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, want);
      errors++;
    end
  endtask

  task automatic check_rsp(input string name, input wb_rsp_t got, input exp_t e);
    check_val({name, ".ack"}, 32'(got.ack), 32'(e.rsp.ack));
    check_val({name, ".err"}, 32'(got.err), 32'(e.rsp.err));
    if (e.chk_dat) check_val({name, ".dat"}, got.dat, e.rsp.dat);
  endtask

  task automatic check_host();
    @(negedge HCLK);
    check_val("test_done_o", 32'(test_done), 32'(tohost_model[0]));
    check_val("test_code_o", 32'(test_code), 32'(tohost_model[XLEN-1:1]));
  endtask

  // Compares every port on each falling edge
  always @(negedge HCLK) begin : compare
    exp_t e_ins;
    exp_t e_dat;
    exp_t e_uart;
    e_ins  = '0;
    e_dat  = '0;
    e_uart = '0;
    if (rst_n) begin
      // Pop what is due now, otherwise expect a quiet bus
      if (ins_q.size() > 0 && ins_q[0].at == cyc_cnt) e_ins = ins_q.pop_front();
      if (dat_q.size() > 0 && dat_q[0].at == cyc_cnt) e_dat = dat_q.pop_front();
      if (uart_q.size() > 0 && uart_q[0].at == cyc_cnt) e_uart = uart_q.pop_front();
      check_rsp("ins_rsp_o", ins_rsp, e_ins);
      check_rsp("dat_rsp_o", dat_rsp, e_dat);
      check_val("uart_valid_o", 32'(uart_valid), 32'(e_uart.rsp.ack));
      if (e_uart.rsp.ack) check_val("uart_data_o", 32'(uart_data), e_uart.rsp.dat);
    end
  end

  ////////////////////
  // Bus driving
  ////////////////////
  function automatic logic responded(input logic use_ins, input logic use_dat);
    return (!use_ins || ins_rsp.ack || ins_rsp.err) && (!use_dat || dat_rsp.ack || dat_rsp.err);
  endfunction

  // One classic cycle on either or both ports
  task automatic issue(input logic use_ins, input wb_req_t ins,
                       input logic use_dat, input wb_req_t dat);
    int waited;
    @(posedge HCLK);
    // Accepted on the next edge, answered one clock later
    if (use_ins) ins_q.push_back(ref_rsp(1'b1, ins, cyc_cnt + 2));
    if (use_dat) dat_q.push_back(ref_rsp(1'b0, dat, cyc_cnt + 2));
    if (use_dat) update_model(dat, cyc_cnt + 2);
    if (use_ins) ins_req <= ins;
    if (use_dat) dat_req <= dat;
    waited = 0;
    do begin
      @(negedge HCLK);
      waited++;
    end while (waited < RSP_LIMIT && !responded(use_ins, use_dat));
    assert (waited < RSP_LIMIT) else begin
      $display("ERROR t=%0t: no ack or err within %0d cycles", $time, RSP_LIMIT);
      errors++;
    end
    @(posedge HCLK);
    ins_req <= '0;
    dat_req <= '0;
  endtask

  task automatic data_op(input wb_req_t r);
    issue(1'b0, '0, 1'b1, r);
  endtask

  task automatic fetch_op(input wb_req_t r);
    issue(1'b1, r, 1'b0, '0);
  endtask

  task automatic end_test(input string name);
    // Let the compare process finish the last cycle
    @(posedge HCLK);
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////
  // Tests
  ////////////////////
  initial begin : main
    logic [RAM_AW-1:0] idx;
    logic [SEL_W-1:0]  sel;
    logic [XLEN-1:0]   val;
    logic              we;
    rst_n   <= 1'b0;
    ins_req <= '0;
    dat_req <= '0;
    repeat (5) @(posedge HCLK);
    rst_n <= 1'b1;

    @(negedge HCLK);
    check_val("ins_rsp_o.ack", 32'(ins_rsp.ack), 32'h0);
    check_val("ins_rsp_o.err", 32'(ins_rsp.err), 32'h0);
    check_val("dat_rsp_o.ack", 32'(dat_rsp.ack), 32'h0);
    check_val("dat_rsp_o.err", 32'(dat_rsp.err), 32'h0);
    check_val("uart_valid_o", 32'(uart_valid), 32'h0);
    check_val("test_done_o", 32'(test_done), 32'h0);
    end_test("reset");

    // Whole array first so every later read is known
    for (int i = 0; i < RAM_WORDS; i++) begin
      idx = RAM_AW'(i);
      data_op(mk_req(1'b1, '1, ram_adr(idx), fill_word(ram_adr(idx))));
    end
    for (int i = 0; i < N_RAND; i++) begin
      we  = 1'(rand_bits(1));
      idx = RAM_AW'(rand_bits(RAM_AW));
      sel = SEL_W'(rand_bits(SEL_W));
      val = rand_bits(XLEN);
      if (sel == '0) sel = '1;
      data_op(mk_req(we, sel, ram_adr(idx), val));
    end
    end_test("data_ram");

    for (int i = 0; i < N_FETCH; i++) begin
      idx = RAM_AW'(rand_bits(RAM_AW));
      fetch_op(mk_req(1'b0, '1, ram_adr(idx), '0));
    end
    // Both ports together, data side half the array away
    for (int i = 0; i < N_PAIR; i++) begin
      we  = 1'(rand_bits(1));
      idx = RAM_AW'(rand_bits(RAM_AW));
      val = rand_bits(XLEN);
      issue(1'b1, mk_req(1'b0, '1, ram_adr(idx), '0),
            1'b1, mk_req(we, '1, ram_adr(idx ^ RAM_AW'(RAM_WORDS / 2)), val));
    end
    end_test("fetch");

    fetch_op(mk_req(1'b1, '1, ram_adr(RAM_AW'(5)), 32'hDEAD_BEEF));
    fetch_op(mk_req(1'b0, '1, TOHOST_ADR, '0));
    fetch_op(mk_req(1'b0, '1, 32'h0000_0100, '0));
    data_op(mk_req(1'b0, '1, 32'h4000_0000, '0));
    // Same word index as word 5, outside the RAM tag
    data_op(mk_req(1'b1, '1, 32'h8000_2014, 32'h1234_5677));
    data_op(mk_req(1'b0, '1, UART_TX_ADR, '0));
    // Nothing above may have landed
    data_op(mk_req(1'b0, '1, ram_adr(RAM_AW'(5)), '0));
    data_op(mk_req(1'b0, '1, TOHOST_ADR, '0));
    end_test("errors");

    for (int i = 0; i < N_UART; i++) begin
      data_op(mk_req(1'b1, '1, UART_TX_ADR, rand_bits(XLEN)));
    end
    end_test("uart");

    // Even value, then odd
    val = rand_bits(XLEN) & ~32'h1;
    data_op(mk_req(1'b1, '1, TOHOST_ADR, val));
    check_host();
    data_op(mk_req(1'b0, '1, TOHOST_ADR, '0));
    val = val | 32'h1;
    data_op(mk_req(1'b1, '1, TOHOST_ADR, val));
    check_host();
    data_op(mk_req(1'b0, '1, TOHOST_ADR, '0));
    end_test("tohost");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Run length bound
  initial begin : watchdog
    #(WD_TIME);
    $display("ERROR: run did not finish within %0d time units", WD_TIME);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_mem_sys.f
source/wb_mem_pkg.sv
source/pma_check.sv
source/wb_port_ctrl.sv
source/wb_dual_ram.sv
source/mmio_host_if.sv
source/wb_mem_sys.sv
tb/wb_mem_sys_tb.sv

//--- Makefile
SIM := obj_dir/Vwb_mem_sys_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): wb_mem_sys.f $(wildcard source/*.sv) tb/wb_mem_sys_tb.sv
	verilator --binary --timing --assert --top-module wb_mem_sys_tb -Mdir obj_dir -f wb_mem_sys.f

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
